// File: hw/linkPkg.sv
package linkPkg;

    // serial link timing in clock cycles
    localparam int BIT_CYCLES = 4;
    // low samples on lane 0 before a start bit counts
    localparam int START_JUDGE = 2;
    // sample cycle inside each bit time
    localparam int SAMPLE_POINT = 2;

    // lane counts
    localparam int REQ_LANES = 4;
    localparam int RESP_LANES = 2;

    // response frames waiting for the transmitter
    localparam int RESP_DEPTH = 4;

    // field widths
    localparam int ADDR_W = 4;
    localparam int DATA_W = 32;
    localparam int TAG_W = 3;

    localparam int MEM_WORDS = 2 ** ADDR_W;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [TAG_W-1:0] tag_t;

    // read request frame
    typedef struct packed {
        tag_t  tag;
        addr_t addr;
    } readReq_t;

    // write request frame
    typedef struct packed {
        tag_t  tag;
        addr_t addr;
        data_t data;
    } writeReq_t;

    // response frame with zero data for a write ack
    typedef struct packed {
        logic  isWrite;
        tag_t  tag;
        data_t data;
    } resp_t;

endpackage

// File: hw/frameRx.sv
`timescale 1ns/10ps

module frameRx #(
    parameter int LANES = linkPkg::REQ_LANES,
    parameter type payload_t = linkPkg::readReq_t
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic [LANES-1:0] lanes,
    input  logic             take,
    output payload_t         frame,
    output logic             frameValid,
    output logic             busy
);
    import linkPkg::*;

    localparam int WIDTH = $bits(payload_t);
    localparam int GROUPS = (WIDTH + LANES - 1) / LANES;
    localparam int TOTAL = GROUPS * LANES;
    // bit 0 is the start bit, GROUPS+1 the stop bit
    localparam int STOP_BIT = GROUPS + 1;
    localparam int PHASE_W = $clog2(BIT_CYCLES);
    localparam int BIT_W = $clog2(STOP_BIT + 1);
    localparam int LOW_W = $clog2(START_JUDGE + 1);

    typedef enum logic [1:0] {
        IDLE,
        RECV,
        HOLD
    } rxState_t;

    rxState_t           state;
    logic [PHASE_W-1:0] phase;
    logic [BIT_W-1:0]   bitNum;
    logic [LOW_W-1:0]   lowCnt;
    logic [TOTAL-1:0]   shiftReg;
    logic               samplePoint;
    logic               stopBit;
    logic               dataBit;

    assign samplePoint = (phase == PHASE_W'(SAMPLE_POINT));
    assign stopBit = (bitNum == BIT_W'(STOP_BIT));
    assign dataBit = (bitNum != '0) && !stopBit;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
            phase <= '0;
            bitNum <= '0;
            lowCnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (lanes[0]) begin
                        lowCnt <= '0;
                    end else if (lowCnt == LOW_W'(START_JUDGE - 1)) begin
                        // start confirmed, already START_JUDGE cycles into the bit
                        state <= RECV;
                        phase <= PHASE_W'(START_JUDGE);
                        bitNum <= '0;
                        lowCnt <= '0;
                    end else begin
                        lowCnt <= lowCnt + 1'b1;
                    end
                end
                RECV: begin
                    if (phase == PHASE_W'(BIT_CYCLES - 1)) begin
                        phase <= '0;
                        bitNum <= bitNum + 1'b1;
                    end else begin
                        phase <= phase + 1'b1;
                    end
                    if (samplePoint && stopBit) begin
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    if (take) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // lane groups enter at the top, first group ends at bit 0
    // the register then holds the frame until take
    always_ff @(posedge clk) begin
        if (state == RECV && samplePoint && dataBit) begin
            shiftReg <= {lanes, shiftReg[TOTAL-1:LANES]};
        end
    end

    assign frame = payload_t'(shiftReg[WIDTH-1:0]);
    assign frameValid = (state == HOLD);
    assign busy = (state != IDLE);

endmodule

// File: hw/frameTx.sv
`timescale 1ns/10ps

module frameTx #(
    parameter int LANES = linkPkg::RESP_LANES,
    parameter type payload_t = linkPkg::resp_t
) (
    input  logic             clk,
    input  logic             rstn,
    input  payload_t         frame,
    input  logic             push,
    output logic             full,
    output logic [LANES-1:0] lanes
);
    import linkPkg::*;

    localparam int WIDTH = $bits(payload_t);
    localparam int GROUPS = (WIDTH + LANES - 1) / LANES;
    localparam int TOTAL = GROUPS * LANES;
    localparam int STOP_BIT = GROUPS + 1;
    localparam int PHASE_W = $clog2(BIT_CYCLES);
    localparam int BIT_W = $clog2(STOP_BIT + 1);
    localparam int PTR_W = $clog2(RESP_DEPTH);
    localparam int CNT_W = $clog2(RESP_DEPTH + 1);

    payload_t           fifo [RESP_DEPTH];
    logic [PTR_W-1:0]   wrPtr;
    logic [PTR_W-1:0]   rdPtr;
    logic [CNT_W-1:0]   count;
    logic               doPush;
    logic               doPop;
    logic               sending;
    logic [PHASE_W-1:0] phase;
    logic [BIT_W-1:0]   bitNum;
    logic [TOTAL-1:0]   shiftReg;
    logic               bitEnd;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(RESP_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (count == CNT_W'(RESP_DEPTH));
    assign doPush = push && !full;
    // next frame leaves only once the line is idle
    assign doPop = !sending && (count != '0);
    assign bitEnd = (phase == PHASE_W'(BIT_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (doPush) begin
            fifo[wrPtr] <= frame;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doPush, doPop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // start bit, GROUPS lane groups, stop bit
    always_ff @(posedge clk) begin
        if (!rstn) begin
            sending <= 1'b0;
            phase <= '0;
            bitNum <= '0;
            lanes <= '1;
        end else if (doPop) begin
            sending <= 1'b1;
            phase <= '0;
            bitNum <= '0;
            lanes <= ~LANES'(1);
        end else if (sending) begin
            if (bitEnd) begin
                phase <= '0;
                bitNum <= bitNum + 1'b1;
                if (bitNum == BIT_W'(STOP_BIT)) begin
                    sending <= 1'b0;
                end else if (bitNum == BIT_W'(GROUPS)) begin
                    lanes <= '1;
                end else begin
                    lanes <= shiftReg[LANES-1:0];
                end
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // lowest group goes out first, top pad bits stay zero
    always_ff @(posedge clk) begin
        if (doPop) begin
            shiftReg <= TOTAL'(fifo[rdPtr]);
        end else if (sending && bitEnd && bitNum < BIT_W'(GROUPS)) begin
            shiftReg <= shiftReg >> LANES;
        end
    end

endmodule

// File: hw/accessUnit.sv
`timescale 1ns/10ps

module accessUnit (
    input  logic               clk,
    input  logic               rstn,
    input  linkPkg::readReq_t  readReq,
    input  logic               readValid,
    input  linkPkg::writeReq_t writeReq,
    input  logic               writeValid,
    input  logic               full,
    output logic               readTake,
    output logic               writeTake,
    output linkPkg::resp_t     resp,
    output logic               push
);
    import linkPkg::*;

    data_t mem [MEM_WORDS];
    logic  canIssue;
    logic  doWrite;
    logic  doRead;
    resp_t respNext;

    // no decision in a take cycle, so full already counts the last push
    // and the taken frame is not seen twice
    assign canIssue = !push && !full;
    // writes win a tie
    assign doWrite = canIssue && writeValid;
    assign doRead = canIssue && readValid && !writeValid;

    always_comb begin
        respNext = '0;
        if (doWrite) begin
            respNext.isWrite = 1'b1;
            respNext.tag = writeReq.tag;
        end else begin
            respNext.isWrite = 1'b0;
            respNext.tag = readReq.tag;
            respNext.data = mem[readReq.addr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            writeTake <= 1'b0;
            readTake <= 1'b0;
            push <= 1'b0;
        end else begin
            writeTake <= doWrite;
            readTake <= doRead;
            push <= doWrite || doRead;
        end
    end

    // word memory starts out all zero
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (doWrite) begin
            mem[writeReq.addr] <= writeReq.data;
        end
    end

    // response leaves together with push
    always_ff @(posedge clk) begin
        if (doWrite || doRead) begin
            resp <= respNext;
        end
    end

endmodule

// File: hw/memLinkEndpoint.sv
`timescale 1ns/10ps

module memLinkEndpoint (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [linkPkg::REQ_LANES-1:0]  readLanes,
    input  logic [linkPkg::REQ_LANES-1:0]  writeLanes,
    output logic                           readBusy,
    output logic                           writeBusy,
    output logic [linkPkg::RESP_LANES-1:0] respLanes
);
    import linkPkg::*;

    readReq_t  readReq;
    logic      readValid;
    logic      readTake;
    writeReq_t writeReq;
    logic      writeValid;
    logic      writeTake;
    resp_t     resp;
    logic      push;
    logic      full;

    // read request link
    frameRx #(
        .LANES(REQ_LANES),
        .payload_t(readReq_t)
    ) readRx (
        .clk(clk),
        .rstn(rstn),
        .lanes(readLanes),
        .take(readTake),
        .frame(readReq),
        .frameValid(readValid),
        .busy(readBusy)
    );

    // write request link
    frameRx #(
        .LANES(REQ_LANES),
        .payload_t(writeReq_t)
    ) writeRx (
        .clk(clk),
        .rstn(rstn),
        .lanes(writeLanes),
        .take(writeTake),
        .frame(writeReq),
        .frameValid(writeValid),
        .busy(writeBusy)
    );

    accessUnit access (
        .clk(clk),
        .rstn(rstn),
        .readReq(readReq),
        .readValid(readValid),
        .writeReq(writeReq),
        .writeValid(writeValid),
        .full(full),
        .readTake(readTake),
        .writeTake(writeTake),
        .resp(resp),
        .push(push)
    );

    // response link
    frameTx #(
        .LANES(RESP_LANES),
        .payload_t(resp_t)
    ) respTx (
        .clk(clk),
        .rstn(rstn),
        .frame(resp),
        .push(push),
        .full(full),
        .lanes(respLanes)
    );

endmodule

// File: tb/linkTbUtil.svh
`ifndef LINK_TB_UTIL_SVH
`define LINK_TB_UTIL_SVH

// response frame on the response link
localparam int RESP_BITS = $bits(resp_t);
localparam int RESP_GROUPS = (RESP_BITS + RESP_LANES - 1) / RESP_LANES;

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
endfunction

// start bit, data groups, stop bit
function automatic int frameCycles(input int width, input int lanes);
    return (2 + (width + lanes - 1) / lanes) * BIT_CYCLES;
endfunction

// one request frame onto the read or write link with the lowest bits first
task automatic sendFrame(input bit toWrite, input logic [63:0] bits, input int width,
                         output int stall);
    int groups;
    logic [REQ_LANES-1:0] group;
    groups = (width + REQ_LANES - 1) / REQ_LANES;
    stall = 0;
    // far end holds busy while its frame is pending
    @(negedge clk);
    while ((toWrite ? writeBusy : readBusy) !== 1'b0) begin
        stall++;
        @(negedge clk);
    end
    @(posedge clk);
    for (int b = 0; b <= groups + 1; b++) begin
        if (b == 0) begin
            group = ~REQ_LANES'(1);
        end else if (b == groups + 1) begin
            group = '1;
        end else begin
            group = REQ_LANES'(bits >> ((b - 1) * REQ_LANES));
        end
        if (toWrite) begin
            writeLanes <= group;
        end else begin
            readLanes <= group;
        end
        repeat (BIT_CYCLES) @(posedge clk);
    end
endtask

// sampled mid bit on the falling edge
task automatic collectResp(output resp_t r, output bit stopOk);
    logic [RESP_GROUPS*RESP_LANES-1:0] bits;
    bits = '0;
    @(negedge clk);
    while (respLanes[0] !== 1'b0) begin
        @(negedge clk);
    end
    repeat (BIT_CYCLES / 2) @(negedge clk);
    for (int g = 0; g < RESP_GROUPS; g++) begin
        repeat (BIT_CYCLES) @(negedge clk);
        bits = {respLanes, bits[RESP_GROUPS*RESP_LANES-1:RESP_LANES]};
    end
    repeat (BIT_CYCLES) @(negedge clk);
    stopOk = (respLanes === '1);
    r = resp_t'(bits[RESP_BITS-1:0]);
endtask

`endif

// File: tb/memLinkEndpointTb.sv
`timescale 1ns/10ps

module memLinkEndpointTb;
    import linkPkg::*;

    localparam int OPS = 80;
    localparam logic [15:0] SEED = 16'd20501;
    // waits longer than this only come from a full response FIFO
    localparam int STALL_MIN = 4 * BIT_CYCLES;

    logic                  clk;
    logic                  rstn;
    logic [REQ_LANES-1:0]  readLanes;
    logic [REQ_LANES-1:0]  writeLanes;
    logic                  readBusy;
    logic                  writeBusy;
    logic [RESP_LANES-1:0] respLanes;

    logic [15:0] lfsr;
    readReq_t    readList[$];
    writeReq_t   writeList[$];
    data_t       modelMem [MEM_WORDS];
    int          readSent = 0;
    int          writeSent = 0;
    int          readHead = 0;
    int          writeHead = 0;
    int          respCount = 0;
    int          cycles = 0;
    int          cycleLimit = 0;
    int          readStallMax = 0;
    int          writeStallMax = 0;
    bit          readDone = 1'b0;
    bit          writeDone = 1'b0;

    `include "linkTbUtil.svh"

    memLinkEndpoint i_memLinkEndpoint (
        .clk(clk),
        .rstn(rstn),
        .readLanes(readLanes),
        .writeLanes(writeLanes),
        .readBusy(readBusy),
        .writeBusy(writeBusy),
        .respLanes(respLanes)
    );

    always #2 clk = ~clk;

    // one LFSR step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            val = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkResp(input resp_t got, input resp_t exp);
        if (got !== exp) begin
            abortRun($sformatf("FAILED at %0t: respLanes got %h, expected %h",
                               $time, got, exp));
        end
    endtask

    task automatic checkBusy(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("FAILED at %0t: %s got %b, expected %b",
                               $time, name, got, exp));
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles > cycleLimit) begin
            abortRun($sformatf("timeout after %0d cycles, %0d of %0d responses missing",
                               cycles, OPS - respCount, OPS));
        end
    end

    initial begin
        readReq_t    rd;
        writeReq_t   wr;
        logic [31:0] pick;
        int          worst;
        clk = 1'b0;
        rstn = 1'b0;
        readLanes = '1;
        writeLanes = '1;
        lfsr = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            modelMem[i] = '0;
        end
        // link bit first, then tag, address and data
        for (int i = 0; i < OPS; i++) begin
            pick = randBits(1);
            if (pick[0]) begin
                wr.tag = tag_t'(randBits(TAG_W));
                wr.addr = addr_t'(randBits(ADDR_W));
                wr.data = randBits(DATA_W);
                writeList.push_back(wr);
            end else begin
                rd.tag = tag_t'(randBits(TAG_W));
                rd.addr = addr_t'(randBits(ADDR_W));
                readList.push_back(rd);
            end
        end
        worst = readList.size() * frameCycles($bits(readReq_t), REQ_LANES)
              + writeList.size() * frameCycles($bits(writeReq_t), REQ_LANES)
              + OPS * frameCycles(RESP_BITS, RESP_LANES);
        cycleLimit = 3 * worst;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        wait (readDone && writeDone && respCount == OPS);
        // a duplicated response would show up in here
        repeat (3 * frameCycles(RESP_BITS, RESP_LANES)) @(negedge clk);
        checkBusy("readBusy", readBusy, 1'b0);
        checkBusy("writeBusy", writeBusy, 1'b0);
        if (readStallMax < STALL_MIN && writeStallMax < STALL_MIN) begin
            abortRun("busy never stayed high from response FIFO back-pressure");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

    initial begin : readSender
        int stall;
        wait (rstn === 1'b1);
        for (int i = 0; i < readList.size(); i++) begin
            sendFrame(1'b0, 64'(readList[i]), $bits(readReq_t), stall);
            readSent++;
            if (stall > readStallMax) begin
                readStallMax = stall;
            end
        end
        readDone = 1'b1;
    end

    initial begin : writeSender
        int stall;
        wait (rstn === 1'b1);
        for (int i = 0; i < writeList.size(); i++) begin
            sendFrame(1'b1, 64'(writeList[i]), $bits(writeReq_t), stall);
            writeSent++;
            if (stall > writeStallMax) begin
                writeStallMax = stall;
            end
        end
        writeDone = 1'b1;
    end

    // responses come back in execution order, each link in its send order
    initial begin : respChecker
        resp_t     got;
        resp_t     exp;
        bit        stopOk;
        readReq_t  rd;
        writeReq_t wr;
        wait (rstn === 1'b1);
        forever begin
            collectResp(got, stopOk);
            if (!stopOk) begin
                abortRun("response frame ended without a high stop bit");
            end
            exp = '0;
            if (got.isWrite) begin
                if (writeHead >= writeSent) begin
                    abortRun("write acknowledge arrived with no write request pending");
                end
                wr = writeList[writeHead];
                writeHead++;
                modelMem[wr.addr] = wr.data;
                exp.isWrite = 1'b1;
                exp.tag = wr.tag;
            end else begin
                if (readHead >= readSent) begin
                    abortRun("read response arrived with no read request pending");
                end
                rd = readList[readHead];
                readHead++;
                exp.tag = rd.tag;
                exp.data = modelMem[rd.addr];
            end
            checkResp(got, exp);
            respCount++;
        end
    end

endmodule

// File: build.f
+incdir+tb
hw/linkPkg.sv
hw/frameRx.sv
hw/frameTx.sv
hw/accessUnit.sv
hw/memLinkEndpoint.sv
tb/memLinkEndpointTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= memLinkEndpointTb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard tb/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "no result found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
